/* rtl/mem_map_pkg.sv */
// Memory map package for the data memory.
// Holds the data word geometry, the word type and the default RAM base.
package mem_map_pkg;

    // Width of one data word in bits.
    localparam int xlen = 64;

    // Number of byte lanes in one word.
    localparam int word_bytes = xlen / 8;

    // One full data word, used for addresses as well as data.
    typedef logic [xlen-1:0] dword_t;

    // Address of the first byte of the RAM in the core's address space.
    localparam dword_t default_ram_base = 64'h8000_0000;

endpackage

/* rtl/lsu_pkg.sv */
// Load/store access package.
// Access width codes, the byte mask type and lane offset alignment.
package lsu_pkg;

    // Number of address bits that select a byte lane inside a word.
    localparam int offset_bits = $clog2(mem_map_pkg::word_bytes);

    // The code is log2 of the access size in bytes.
    typedef enum logic [1:0] {
        width_byte  = 2'b00,
        width_half  = 2'b01,
        width_word  = 2'b10,
        width_dword = 2'b11
    } access_width_t;

    // One write enable bit per byte lane.
    typedef logic [mem_map_pkg::word_bytes-1:0] byte_mask_t;

    // Clears the offset bits below the access size so every access is aligned.
    function automatic logic [offset_bits-1:0] align_offset(
        input logic [offset_bits-1:0] offset,
        input access_width_t          width
    );
        logic [offset_bits-1:0] low_mask;
        low_mask = offset_bits'((1 << width) - 1);
        return offset & ~low_mask;
    endfunction

endpackage

/* rtl/mux_key.sv */
// Keyed lookup multiplexer.
// Searches a packed table of key and payload pairs, with a fallback value.
`timescale 1ns/1ps

module mux_key #(
    parameter int  nr_key    = 2,
    parameter int  key_len   = 2,
    parameter type payload_t = logic [7:0]
) (
    input  logic [key_len-1:0]                               key,
    input  logic [nr_key*(key_len+$bits(payload_t))-1:0]    lut,
    input  payload_t                                         default_out,
    output payload_t                                         out
);

    localparam int pay_len  = $bits(payload_t);
    localparam int pair_len = key_len + pay_len;

    // The table is written as {key0, data0, key1, data1, ...}, so the first
    // pair sits in the top bits and the last pair at bit zero.
    logic [key_len-1:0] entry_key [nr_key];
    payload_t           entry_out [nr_key];

    always_comb begin
        for (int i = 0; i < nr_key; i++) begin
            entry_key[i] = lut[i*pair_len+pay_len +: key_len];
            entry_out[i] = lut[i*pair_len +: pay_len];
        end
    end

    // Scan from the last pair upwards so that the earliest listed match wins.
    always_comb begin
        out = default_out;
        for (int i = 0; i < nr_key; i++) begin
            if (entry_key[i] == key) begin
                out = entry_out[i];
            end
        end
    end

endmodule

/* rtl/store_align.sv */
// Store alignment.
// Turns address, width and data into a byte write mask and lane-placed data.
`timescale 1ns/1ps

module store_align (
    input  mem_map_pkg::dword_t        waddr,
    input  lsu_pkg::access_width_t     wwidth,
    input  mem_map_pkg::dword_t        wdata,
    output lsu_pkg::byte_mask_t        byte_mask,
    output mem_map_pkg::dword_t        lane_data
);

    import mem_map_pkg::*;
    import lsu_pkg::*;

    byte_mask_t             base_mask;
    logic [offset_bits-1:0] offset;

    // Mask for an access starting at lane zero, one bit per byte written.
    mux_key #(
        .nr_key    (4),
        .key_len   (2),
        .payload_t (byte_mask_t)
    ) u_mask_mux (
        .key         (wwidth),
        .lut         ({
            width_byte,  8'h01,
            width_half,  8'h03,
            width_word,  8'h0f,
            width_dword, 8'hff
        }),
        .default_out ('0),
        .out         (base_mask)
    );

    // Address bits below the access size are dropped.
    assign offset = align_offset(waddr[offset_bits-1:0], wwidth);

    // Move the mask and the data up to the addressed lane. Data bits that
    // land above the access size fall outside the mask and are not written.
    assign byte_mask = base_mask << offset;
    assign lane_data = wdata << {offset, 3'b000};

endmodule

/* rtl/load_extract.sv */
// Load extraction.
// Picks the addressed lane of a read word and zero- or sign-extends it.
`timescale 1ns/1ps

module load_extract (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ren,
    input  logic [lsu_pkg::offset_bits-1:0] raddr_offset,
    input  lsu_pkg::access_width_t        rwidth,
    input  logic                          runsigned,
    input  mem_map_pkg::dword_t           rword,
    output mem_map_pkg::dword_t           rdata,
    output logic                          rd_valid
);

    import mem_map_pkg::*;
    import lsu_pkg::*;

    logic [offset_bits-1:0] offset_q;
    access_width_t          width_q;
    logic                   unsigned_q;

    logic [offset_bits-1:0] offset;
    dword_t                 shifted;
    dword_t                 zext_val;
    dword_t                 sext_byte;
    dword_t                 sext_half;
    dword_t                 sext_word;

    // The valid pulse follows every strobe by one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= ren;
        end
    end

    // Access controls are captured on the same edge as the RAM word so both
    // line up in the result cycle.
    always_ff @(posedge clk) begin
        if (ren) begin
            offset_q   <= raddr_offset;
            width_q    <= rwidth;
            unsigned_q <= runsigned;
        end
    end

    assign offset  = align_offset(offset_q, width_q);
    assign shifted = rword >> {offset, 3'b000};

    // Sign extensions of the low lane, by access size.
    assign sext_byte = {{(xlen-8){shifted[7]}}, shifted[7:0]};
    assign sext_half = {{(xlen-16){shifted[15]}}, shifted[15:0]};
    assign sext_word = {{(xlen-32){shifted[31]}}, shifted[31:0]};

    // Zero-extended lane for the registered width.
    mux_key #(
        .nr_key    (4),
        .key_len   (2),
        .payload_t (dword_t)
    ) u_lane_mux (
        .key         (width_q),
        .lut         ({
            width_byte,  dword_t'(shifted[7:0]),
            width_half,  dword_t'(shifted[15:0]),
            width_word,  dword_t'(shifted[31:0]),
            width_dword, shifted
        }),
        .default_out (shifted),
        .out         (zext_val)
    );

    // Signed byte, half and word loads take the sign-extended value.
    // Anything else, including every double-word load, keeps the zero extension.
    mux_key #(
        .nr_key    (3),
        .key_len   (3),
        .payload_t (dword_t)
    ) u_ext_mux (
        .key         ({unsigned_q, width_q}),
        .lut         ({
            {1'b0, width_byte}, sext_byte,
            {1'b0, width_half}, sext_half,
            {1'b0, width_word}, sext_word
        }),
        .default_out (zext_val),
        .out         (rdata)
    );

endmodule

/* rtl/data_ram.sv */
// Data RAM of 64-bit words.
// Base-relative word indexing, byte write enables and a registered read port.
`timescale 1ns/1ps

module data_ram #(
    parameter int                  addr_width = 10,
    parameter mem_map_pkg::dword_t ram_base   = mem_map_pkg::default_ram_base
) (
    input  logic                   clk,
    input  logic                   wen,
    input  mem_map_pkg::dword_t    waddr,
    input  lsu_pkg::byte_mask_t    byte_mask,
    input  mem_map_pkg::dword_t    lane_data,
    input  logic                   ren,
    input  mem_map_pkg::dword_t    raddr,
    output mem_map_pkg::dword_t    rword
);

    import mem_map_pkg::*;

    localparam int depth       = 2 ** addr_width;
    localparam int offset_bits = $clog2(word_bytes);

    dword_t                mem [depth];
    dword_t                wrel;
    dword_t                rrel;
    logic [addr_width-1:0] widx;
    logic [addr_width-1:0] ridx;

    // Drop the byte offset and keep only the low index bits, so addresses
    // outside the RAM wrap onto it.
    assign wrel = waddr - ram_base;
    assign rrel = raddr - ram_base;
    assign widx = wrel[offset_bits +: addr_width];
    assign ridx = rrel[offset_bits +: addr_width];

    // Only the enabled lanes change; the rest of the word keeps its value.
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < word_bytes; b++) begin
                if (byte_mask[b]) begin
                    mem[widx][b*8 +: 8] <= lane_data[b*8 +: 8];
                end
            end
        end
    end

    // A read and a write to the same word on one edge return the old word.
    always_ff @(posedge clk) begin
        if (ren) begin
            rword <= mem[ridx];
        end
    end

endmodule

/* rtl/dmem_top.sv */
// Data memory top level.
// Store alignment feeds the RAM; load extraction shapes the read word.
`timescale 1ns/1ps

module dmem_top #(
    parameter int                  addr_width = 10,
    parameter mem_map_pkg::dword_t ram_base   = mem_map_pkg::default_ram_base
) (
    input  logic                       clk,
    input  logic                       rst,

    // Store port.
    input  logic                       wen,
    input  mem_map_pkg::dword_t        waddr,
    input  mem_map_pkg::dword_t        wdata,
    input  lsu_pkg::access_width_t     wwidth,

    // Load port.
    input  logic                       ren,
    input  mem_map_pkg::dword_t        raddr,
    input  lsu_pkg::access_width_t     rwidth,
    input  logic                       runsigned,
    output mem_map_pkg::dword_t        rdata,
    output logic                       rd_valid
);

    import mem_map_pkg::*;
    import lsu_pkg::*;

    byte_mask_t byte_mask;
    dword_t     lane_data;
    dword_t     rword;

    store_align u_store_align (
        .waddr     (waddr),
        .wwidth    (wwidth),
        .wdata     (wdata),
        .byte_mask (byte_mask),
        .lane_data (lane_data)
    );

    data_ram #(
        .addr_width (addr_width),
        .ram_base   (ram_base)
    ) u_data_ram (
        .clk       (clk),
        .wen       (wen),
        .waddr     (waddr),
        .byte_mask (byte_mask),
        .lane_data (lane_data),
        .ren       (ren),
        .raddr     (raddr),
        .rword     (rword)
    );

    // The lane offset is taken from the raw address and aligned inside.
    load_extract u_load_extract (
        .clk          (clk),
        .rst          (rst),
        .ren          (ren),
        .raddr_offset (raddr[offset_bits-1:0]),
        .rwidth       (rwidth),
        .runsigned    (runsigned),
        .rword        (rword),
        .rdata        (rdata),
        .rd_valid     (rd_valid)
    );

endmodule

/* dv/dmem_checker.sv */
// Bound checker for the data memory.
// Read valid timing, reset state and store byte mask shape.
`timescale 1ns/1ps

module dmem_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   ren,
    input logic                   rd_valid,
    input logic                   wen,
    input lsu_pkg::access_width_t wwidth,
    input lsu_pkg::byte_mask_t    byte_mask
);

    import lsu_pkg::*;

    // Failed assertions, read by the testbench at the end of the run.
    int unsigned fail_count = 0;

    // True when the set bits of the mask form one unbroken run.
    function automatic logic is_contiguous(input byte_mask_t m);
        byte_mask_t low_bit;
        low_bit = m & (~m + 1'b1);
        return ((m + low_bit) & m) == '0;
    endfunction

    // Each strobe gives one valid pulse on the next cycle and nothing else.
    valid_follows_ren: assert property (@(posedge clk) disable iff (rst)
        rd_valid == $past(ren))
        else begin
            $error("rd_valid does not follow ren by one cycle");
            fail_count++;
        end

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !rd_valid)
        else begin
            $error("rd_valid is high after a reset cycle");
            fail_count++;
        end

    // A store of 2**w bytes enables exactly that many neighbouring lanes.
    mask_matches_width: assert property (@(posedge clk) disable iff (rst)
        wen |-> ($countones(byte_mask) == (1 << wwidth)) && is_contiguous(byte_mask))
        else begin
            $error("byte mask shape does not match the store width");
            fail_count++;
        end

endmodule

bind dmem_top dmem_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .ren       (ren),
    .rd_valid  (rd_valid),
    .wen       (wen),
    .wwidth    (wwidth),
    .byte_mask (byte_mask)
);

/* dv/dmem_tb.sv */
// Testbench for the data memory.
// LFSR driven stores and loads checked against a byte-array model.
`timescale 1ns/1ps

module dmem_tb;

    import mem_map_pkg::*;
    import lsu_pkg::*;

    localparam int addr_width   = 6;
    localparam int n_words      = 2 ** addr_width;
    localparam int n_bytes      = n_words * word_bytes;
    localparam int reset_cycles = 8;
    localparam int n_random     = 1600;
    localparam int n_extract    = 2 + 4 * 8 * 2 * 2;
    localparam int n_wrap       = 64;
    localparam int max_cycles   = reset_cycles + 2 * n_words + n_random + n_extract
                                  + 2 * n_wrap + 200;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    logic          wen = 1'b0;
    dword_t        waddr = '0;
    dword_t        wdata = '0;
    access_width_t wwidth = width_byte;
    logic          ren = 1'b0;
    dword_t        raddr = '0;
    access_width_t rwidth = width_byte;
    logic          runsigned = 1'b0;
    dword_t        rdata;
    logic          rd_valid;

    logic [7:0]  model_mem [n_bytes];
    dword_t      expected_q [$];
    dword_t      expected_data;
    logic        ren_seen = 1'b0;
    logic [15:0] lfsr_state = 16'd6345;
    int          cycle_count = 0;
    int unsigned check_count = 0;
    int unsigned mismatch_count = 0;
    int unsigned other_count = 0;

    dmem_top #(
        .addr_width (addr_width),
        .ram_base   (default_ram_base)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata),
        .wwidth    (wwidth),
        .ren       (ren),
        .raddr     (raddr),
        .rwidth    (rwidth),
        .runsigned (runsigned),
        .rdata     (rdata),
        .rd_valid  (rd_valid)
    );

    always #5 clk = ~clk;

    // Galois form with taps at 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output dword_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    // Byte address in the model of the first byte of the addressed word.
    function automatic int word_base(input dword_t addr);
        dword_t rel;
        rel = (addr - default_ram_base) / word_bytes;
        return int'(rel % n_words) * word_bytes;
    endfunction

    // Lane offset with the bits below the access size cleared.
    function automatic int lane_offset(input dword_t addr, input access_width_t width);
        int size;
        size = 1 << width;
        return (int'(addr[2:0]) / size) * size;
    endfunction

    task automatic model_store(input dword_t addr, input access_width_t width, input dword_t data);
        int pos;
        pos = word_base(addr) + lane_offset(addr, width);
        for (int i = 0; i < (1 << width); i++) begin
            model_mem[pos + i] = data[i*8 +: 8];
        end
    endtask

    function automatic dword_t model_load(input dword_t addr, input access_width_t width,
                                          input logic uns);
        dword_t v;
        int     pos;
        int     size;
        size = 1 << width;
        pos  = word_base(addr) + lane_offset(addr, width);
        v    = '0;
        for (int i = 0; i < size; i++) begin
            v[i*8 +: 8] = model_mem[pos + i];
        end
        if (!uns && size < word_bytes && v[size*8-1]) begin
            v = v | (~64'h0 << (size * 8));
        end
        return v;
    endfunction

    task automatic check_value(input string name, input dword_t got, input dword_t exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // The expected read value is taken before the same-cycle store reaches the model,
    // since the RAM returns the old word in that case.
    task automatic drive_cycle(input logic do_write, input dword_t w_addr,
                               input access_width_t w_width, input dword_t w_data,
                               input logic do_read, input dword_t r_addr,
                               input access_width_t r_width, input logic r_uns);
        @(posedge clk);
        wen       <= do_write;
        waddr     <= w_addr;
        wwidth    <= w_width;
        wdata     <= w_data;
        ren       <= do_read;
        raddr     <= r_addr;
        rwidth    <= r_width;
        runsigned <= r_uns;
        if (do_read) begin
            expected_q.push_back(model_load(r_addr, r_width, r_uns));
        end
        if (do_write) begin
            model_store(w_addr, w_width, w_data);
        end
    endtask

    task automatic store_only(input dword_t addr, input access_width_t width, input dword_t data);
        drive_cycle(1'b1, addr, width, data, 1'b0, '0, width_byte, 1'b0);
    endtask

    task automatic load_only(input dword_t addr, input access_width_t width, input logic uns);
        drive_cycle(1'b0, '0, width_byte, '0, 1'b1, addr, width, uns);
    endtask

    // Outputs are sampled mid-cycle. A valid pulse is due one cycle after each strobe.
    always @(negedge clk) begin
        check_value("rd_valid", dword_t'(rd_valid), dword_t'(ren_seen));
        if (ren_seen) begin
            if (expected_q.size() == 0) begin
                other_count++;
                $display("A read result arrived with no expected value queued at %0t", $time);
            end else begin
                expected_data = expected_q.pop_front();
                check_value("rdata", rdata, expected_data);
            end
        end
        ren_seen = ren;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        dword_t        rnd;
        dword_t        hi;
        dword_t        lo;
        dword_t        w_addr;
        dword_t        r_addr;
        dword_t        w_data;
        access_width_t w_width;
        access_width_t r_width;
        logic          do_write;
        logic          do_read;
        logic          r_uns;
        int unsigned   total;

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Fill every word, then read each one back whole.
        for (int i = 0; i < n_words; i++) begin
            random_bits(64, rnd);
            store_only(default_ram_base + i * word_bytes, width_dword, rnd);
        end
        for (int i = 0; i < n_words; i++) begin
            load_only(default_ram_base + i * word_bytes, width_dword, 1'b0);
        end

        // Random mix of stores, loads and idle cycles.
        for (int n = 0; n < n_random; n++) begin
            random_bits(1, rnd);
            do_write = rnd[0];
            random_bits(1, rnd);
            do_read = rnd[0];
            random_bits(2, rnd);
            w_width = access_width_t'(rnd[1:0]);
            random_bits(9, rnd);
            w_addr = default_ram_base + rnd;
            random_bits(64, w_data);
            random_bits(2, rnd);
            r_width = access_width_t'(rnd[1:0]);
            random_bits(1, rnd);
            r_uns = rnd[0];
            random_bits(2, rnd);
            if (rnd[1:0] == 2'b00) begin
                // Same word as the store, often in the same cycle.
                random_bits(3, rnd);
                r_addr = {w_addr[63:3], rnd[2:0]};
            end else begin
                random_bits(9, rnd);
                r_addr = default_ram_base + rnd;
            end
            drive_cycle(do_write, w_addr, w_width, w_data, do_read, r_addr, r_width, r_uns);
        end

        // Every width, offset and extension on one word with all lane top bits set
        // and one with all of them clear.
        random_bits(64, rnd);
        store_only(default_ram_base + 3 * word_bytes, width_dword, rnd | 64'h8080_8080_8080_8080);
        random_bits(64, rnd);
        store_only(default_ram_base + 5 * word_bytes, width_dword, rnd & 64'h7f7f_7f7f_7f7f_7f7f);
        for (int w = 0; w < 4; w++) begin
            for (int off = 0; off < 8; off++) begin
                for (int u = 0; u < 2; u++) begin
                    for (int k = 0; k < 2; k++) begin
                        r_addr = default_ram_base + (3 + 2 * k) * word_bytes + off;
                        load_only(r_addr, access_width_t'(w), u[0]);
                    end
                end
            end
        end

        // Stores far above the RAM land on their alias, read back through another alias.
        for (int n = 0; n < n_wrap; n++) begin
            random_bits(16, hi);
            random_bits(9, lo);
            random_bits(2, rnd);
            w_width = access_width_t'(rnd[1:0]);
            random_bits(64, w_data);
            store_only(default_ram_base + (hi << 9) + lo, w_width, w_data);
            random_bits(16, hi);
            load_only(default_ram_base + (hi << 9) + lo, width_dword, 1'b0);
        end

        drive_cycle(1'b0, '0, width_byte, '0, 1'b0, '0, width_byte, 1'b0);
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);

        total = mismatch_count + other_count + dut.u_checker.fail_count;
        $display("Error count: %0d mismatches, %0d other errors, %0d assertion failures in %0d checks",
                 mismatch_count, other_count, dut.u_checker.fail_count, check_count);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* rv64_dmem.f */
rtl/mem_map_pkg.sv
rtl/lsu_pkg.sv
rtl/mux_key.sv
rtl/store_align.sv
rtl/load_extract.sv
rtl/data_ram.sv
rtl/dmem_top.sv
dv/dmem_checker.sv
dv/dmem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the data memory testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dmem_tb \
    -f rv64_dmem.f \
    -Mdir obj_dir \
    -o dmem_sim

./obj_dir/dmem_sim | tee sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
